// ==== logic/stream_pkg.sv ====
package stream_pkg;

    // --------------------
    // Command encoding
    // --------------------

    parameter int OPCODE_WIDTH = 3; // Opcode field of a command.

    // ALU opcodes. Codes 6 and 7 are reserved and execute as errors.
    typedef enum logic [OPCODE_WIDTH-1:0] {
        op_add  = 3'd0, // a + b, wraps.
        op_sub  = 3'd1, // a - b, wraps.
        op_and  = 3'd2,
        op_xor  = 3'd3,
        op_shl  = 3'd4, // a << b[3:0].
        op_max  = 3'd5, // Unsigned maximum.
        op_bad6 = 3'd6,
        op_bad7 = 3'd7
    } alu_op_e;

endpackage : stream_pkg

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter  int DEPTH      = 4,
    parameter  int WIDTH      = 16,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                push,
    input  logic [WIDTH-1:0]    push_data,
    input  logic                pop,
    output logic [WIDTH-1:0]    pop_data,
    output logic                empty,
    output logic                full,
    output logic [ADDR_WIDTH:0] count
);

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [ADDR_WIDTH:0] head;    // Extra top bit tells wrap parity.
    logic [ADDR_WIDTH:0] tail;
    logic                push_ok;
    logic                pop_ok;

    // Same index with opposite wrap bit means full.
    assign full     = ((head ^ tail) == {1'b1, {ADDR_WIDTH{1'b0}}});
    assign empty    = (head == tail);
    assign count    = tail - head;

    assign push_ok  = push && !full;  // Push into a full FIFO is dropped.
    assign pop_ok   = pop && !empty;

    // First word falls through. Zero while empty.
    assign pop_data = empty ? '0 : mem[head[ADDR_WIDTH-1:0]];

    // --------------------
    // Pointers
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push_ok) begin
                tail <= tail + 1'b1;
            end
            if (pop_ok) begin
                head <= head + 1'b1;
            end
        end
    end

    // Storage array.
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[tail[ADDR_WIDTH-1:0]] <= push_data;
        end
    end

endmodule : sync_fifo

// ==== logic/cmd_ingress.sv ====
`timescale 1ns/1ps

module cmd_ingress
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH    = 16,
    parameter int INGRESS_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset_n,
    // Upstream source.
    input  logic                    in_valid,
    input  logic [OPCODE_WIDTH-1:0] in_opcode,
    input  logic [DATA_WIDTH-1:0]   in_operand_a,
    input  logic [DATA_WIDTH-1:0]   in_operand_b,
    output logic                    in_credit,
    // Toward the ALU.
    output logic                    cmd_valid,
    output alu_op_e                 cmd_op,
    output logic [DATA_WIDTH-1:0]   cmd_a,
    output logic [DATA_WIDTH-1:0]   cmd_b,
    input  logic                    cmd_pop
);

    localparam int WORD_WIDTH = OPCODE_WIDTH + 2 * DATA_WIDTH;

    logic [WORD_WIDTH-1:0] in_word;
    logic [WORD_WIDTH-1:0] head_word;
    logic                  fifo_empty;

    // Word layout is {opcode, a, b}.
    assign in_word = {in_opcode, in_operand_a, in_operand_b};

    sync_fifo #(
        .DEPTH (INGRESS_DEPTH),
        .WIDTH (WORD_WIDTH)
    ) u_cmd_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (in_valid),   // Source only sends on a held credit.
        .push_data (in_word),
        .pop       (cmd_pop),
        .pop_data  (head_word),
        .empty     (fifo_empty),
        .full      (),
        .count     ()
    );

    // --------------------
    // Head decode
    // --------------------

    assign cmd_valid = !fifo_empty;
    assign cmd_op    = alu_op_e'(head_word[WORD_WIDTH-1 -: OPCODE_WIDTH]);
    assign cmd_a     = head_word[2*DATA_WIDTH-1 -: DATA_WIDTH];
    assign cmd_b     = head_word[DATA_WIDTH-1:0];

    // One credit back to the source per freed slot.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= cmd_pop && cmd_valid;
        end
    end

endmodule : cmd_ingress

// ==== logic/alu_stage.sv ====
`timescale 1ns/1ps

module alu_stage
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH   = 16,
    parameter int EGRESS_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cmd_valid,
    input  alu_op_e               cmd_op,
    input  logic [DATA_WIDTH-1:0] cmd_a,
    input  logic [DATA_WIDTH-1:0] cmd_b,
    output logic                  cmd_pop,
    output logic                  res_push,
    output logic [DATA_WIDTH-1:0] res_data,
    output logic                  res_error,
    input  logic                  res_credit
);

    localparam int CREDIT_WIDTH = $clog2(EGRESS_DEPTH) + 1;

    logic [CREDIT_WIDTH-1:0] credit_cnt;   // Free egress slots not yet claimed.
    logic                    s1_valid;
    alu_op_e                 s1_op;
    logic [DATA_WIDTH-1:0]   s1_a;
    logic [DATA_WIDTH-1:0]   s1_b;
    logic [DATA_WIDTH-1:0]   alu_result;
    logic                    alu_error;

    // Issue only against a credit. In-flight pushes already spent theirs.
    assign cmd_pop = cmd_valid && (credit_cnt != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_cnt <= CREDIT_WIDTH'(EGRESS_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - CREDIT_WIDTH'(cmd_pop) + CREDIT_WIDTH'(res_credit);
        end
    end

    // --------------------
    // Stage 1, operands
    // --------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= cmd_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            s1_op <= cmd_op;
            s1_a  <= cmd_a;
            s1_b  <= cmd_b;
        end
    end

    // --------------------
    // Stage 2, execute
    // --------------------

    always_comb begin
        alu_error = 1'b0;
        case (s1_op)
            op_add:  alu_result = s1_a + s1_b;      // Wraps at DATA_WIDTH.
            op_sub:  alu_result = s1_a - s1_b;
            op_and:  alu_result = s1_a & s1_b;
            op_xor:  alu_result = s1_a ^ s1_b;
            op_shl:  alu_result = s1_a << s1_b[3:0];
            op_max:  alu_result = (s1_a > s1_b) ? s1_a : s1_b;
            default: begin
                alu_result = '0;                    // Reserved opcode.
                alu_error  = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_push <= 1'b0;
        end else begin
            res_push <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res_data  <= alu_result;
            res_error <= alu_error;
        end
    end

endmodule : alu_stage

// ==== logic/result_egress.sv ====
`timescale 1ns/1ps

module result_egress #(
    parameter int DATA_WIDTH   = 16,
    parameter int EGRESS_DEPTH = 4,
    parameter int SINK_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  reset_n,
    // From the ALU.
    input  logic                  res_push,
    input  logic [DATA_WIDTH-1:0] res_data,
    input  logic                  res_error,
    output logic                  res_credit,
    // Downstream sink.
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_result,
    output logic                  out_error,
    input  logic                  out_credit
);

    localparam int WORD_WIDTH       = DATA_WIDTH + 1;
    localparam int SINK_CREDIT_BITS = $clog2(SINK_CREDITS + 1);

    logic [WORD_WIDTH-1:0]       head_word;
    logic                        fifo_empty;
    logic [SINK_CREDIT_BITS-1:0] sink_credit_cnt;   // Free sink buffer entries.

    // --------------------
    // Result queue
    // --------------------

    sync_fifo #(
        .DEPTH (EGRESS_DEPTH),
        .WIDTH (WORD_WIDTH)
    ) u_res_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (res_push),
        .push_data ({res_error, res_data}),
        .pop       (out_valid),   // Every valid cycle is a transfer.
        .pop_data  (head_word),
        .empty     (fifo_empty),
        .full      (),
        .count     ()
    );

    assign out_valid  = !fifo_empty && (sink_credit_cnt != '0);
    assign out_error  = head_word[DATA_WIDTH];
    assign out_result = head_word[DATA_WIDTH-1:0];

    // --------------------
    // Credits
    // --------------------

    // Spend one per transfer, regain one per sink pulse.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sink_credit_cnt <= SINK_CREDIT_BITS'(SINK_CREDITS);
        end else begin
            sink_credit_cnt <= sink_credit_cnt
                             - SINK_CREDIT_BITS'(out_valid)
                             + SINK_CREDIT_BITS'(out_credit);
        end
    end

    // Freed FIFO slot goes back to the ALU a cycle later.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_credit <= 1'b0;
        end else begin
            res_credit <= out_valid;
        end
    end

endmodule : result_egress

// ==== logic/alu_stream_top.sv ====
`timescale 1ns/1ps

module alu_stream_top
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH    = 16,
    parameter int INGRESS_DEPTH = 4,   // Also the source's starting credits.
    parameter int EGRESS_DEPTH  = 4,   // Also the ALU's starting credits.
    parameter int SINK_CREDITS  = 2
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    in_valid,
    input  logic [OPCODE_WIDTH-1:0] in_opcode,
    input  logic [DATA_WIDTH-1:0]   in_operand_a,
    input  logic [DATA_WIDTH-1:0]   in_operand_b,
    output logic                    in_credit,
    output logic                    out_valid,
    output logic [DATA_WIDTH-1:0]   out_result,
    output logic                    out_error,
    input  logic                    out_credit
);

    // Ingress head to ALU.
    logic                  cmd_valid;
    alu_op_e               cmd_op;
    logic [DATA_WIDTH-1:0] cmd_a;
    logic [DATA_WIDTH-1:0] cmd_b;
    logic                  cmd_pop;

    // ALU to egress.
    logic                  res_push;
    logic [DATA_WIDTH-1:0] res_data;
    logic                  res_error;
    logic                  res_credit;

    cmd_ingress #(
        .DATA_WIDTH    (DATA_WIDTH),
        .INGRESS_DEPTH (INGRESS_DEPTH)
    ) u_ingress (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_valid     (in_valid),
        .in_opcode    (in_opcode),
        .in_operand_a (in_operand_a),
        .in_operand_b (in_operand_b),
        .in_credit    (in_credit),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_a        (cmd_a),
        .cmd_b        (cmd_b),
        .cmd_pop      (cmd_pop)
    );

    alu_stage #(
        .DATA_WIDTH   (DATA_WIDTH),
        .EGRESS_DEPTH (EGRESS_DEPTH)
    ) u_alu (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_a      (cmd_a),
        .cmd_b      (cmd_b),
        .cmd_pop    (cmd_pop),
        .res_push   (res_push),
        .res_data   (res_data),
        .res_error  (res_error),
        .res_credit (res_credit)
    );

    result_egress #(
        .DATA_WIDTH   (DATA_WIDTH),
        .EGRESS_DEPTH (EGRESS_DEPTH),
        .SINK_CREDITS (SINK_CREDITS)
    ) u_egress (
        .clk        (clk),
        .reset_n    (reset_n),
        .res_push   (res_push),
        .res_data   (res_data),
        .res_error  (res_error),
        .res_credit (res_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_error  (out_error),
        .out_credit (out_credit)
    );

endmodule : alu_stream_top

// ==== verification/alu_stream_props.sv ====
`timescale 1ns/1ps

module alu_stream_props #(
    parameter int EGRESS_DEPTH = 4,
    parameter int SINK_CREDITS = 2
) (
    input logic                          clk,
    input logic                          reset_n,
    input logic                          in_valid,
    input logic                          in_credit,
    input logic                          out_valid,
    input logic                          out_credit,
    input logic                          res_push,
    input logic                          ingress_full,
    input logic                          egress_full,
    input logic [$clog2(EGRESS_DEPTH):0] alu_credits
);

    int fail_count = 0;   // Assertion failures so far.
    int sink_held;        // Results the sink has not credited back.

    // Sink side view of the credit loop.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sink_held <= 0;
        end else begin
            sink_held <= sink_held + int'(out_valid) - int'(out_credit);
        end
    end

    // --------------------
    // Credit rules
    // --------------------

    valid_has_credit: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> (sink_held < SINK_CREDITS))
        else begin
            $error("out_valid raised with no sink credit");
            fail_count++;
        end

    alu_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
        alu_credits <= EGRESS_DEPTH)
        else begin
            $error("ALU credit count above EGRESS_DEPTH");
            fail_count++;
        end

    // Both FIFOs rely on credits, so a full push is a protocol bug.
    no_ingress_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        !(in_valid && ingress_full))
        else begin
            $error("Push into a full ingress FIFO");
            fail_count++;
        end

    no_egress_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        !(res_push && egress_full))
        else begin
            $error("Push into a full egress FIFO");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !reset_n |-> (!out_valid && !in_credit))
        else begin
            $error("out_valid or in_credit high during reset");
            fail_count++;
        end

endmodule : alu_stream_props

bind alu_stream_top alu_stream_props #(
    .EGRESS_DEPTH (EGRESS_DEPTH),
    .SINK_CREDITS (SINK_CREDITS)
) u_props (
    .clk          (clk),
    .reset_n      (reset_n),
    .in_valid     (in_valid),
    .in_credit    (in_credit),
    .out_valid    (out_valid),
    .out_credit   (out_credit),
    .res_push     (res_push),
    .ingress_full (u_ingress.u_cmd_fifo.full),
    .egress_full  (u_egress.u_res_fifo.full),
    .alu_credits  (u_alu.credit_cnt)
);

// ==== verification/alu_stream_tb.sv ====
`timescale 1ns/1ps

module alu_stream_tb
    import stream_pkg::*;
;

    localparam int DATA_WIDTH    = 16;
    localparam int INGRESS_DEPTH = 4;
    localparam int EGRESS_DEPTH  = 4;
    localparam int SINK_CREDITS  = 2;
    localparam int TIMEOUT       = 500;   // Cycles per wait.
    localparam int NUM_ROWS      = 13;

    typedef struct {
        alu_op_e               op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] res;
        logic                  err;
    } row_t;

    logic                    clk;
    logic                    reset_n;
    logic                    in_valid;
    logic [OPCODE_WIDTH-1:0] in_opcode;
    logic [DATA_WIDTH-1:0]   in_operand_a;
    logic [DATA_WIDTH-1:0]   in_operand_b;
    logic                    in_credit;
    logic                    out_valid;
    logic [DATA_WIDTH-1:0]   out_result;
    logic                    out_error;
    logic                    out_credit;

    row_t                  rows [NUM_ROWS];
    logic [DATA_WIDTH-1:0] exp_res_q [$];
    logic                  exp_err_q [$];
    logic [DATA_WIDTH-1:0] got_res_q [$];   // Filled by the sink model.
    logic                  got_err_q [$];
    int                    rd_idx = 0;
    int                    sent = 0;
    int                    credit_returns = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    failed_tests = 0;
    int                    test_err_start = 0;
    logic [31:0]           lcg_state = 32'heb10dca0;

    // Sink model state.
    bit sink_stall = 1'b0;
    int sink_hold = 0;
    bit credit_next = 1'b0;
    int owed = 0;        // Entries held by the sink.
    int hold_cnt = 0;

    alu_stream_top #(
        .DATA_WIDTH    (DATA_WIDTH),
        .INGRESS_DEPTH (INGRESS_DEPTH),
        .EGRESS_DEPTH  (EGRESS_DEPTH),
        .SINK_CREDITS  (SINK_CREDITS)
    ) u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_valid     (in_valid),
        .in_opcode    (in_opcode),
        .in_operand_a (in_operand_a),
        .in_operand_b (in_operand_b),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_error    (out_error),
        .out_credit   (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_n && in_credit) begin
            credit_returns++;
        end
    end

    // --------------------
    // Sink model
    // --------------------

    always @(posedge clk) begin
        credit_next = 1'b0;
        if (owed > 0 && !sink_stall) begin
            if (hold_cnt >= sink_hold) begin
                credit_next = 1'b1;   // Free one buffered result.
                owed--;
                hold_cnt = 0;
            end else begin
                hold_cnt++;
            end
        end
        if (reset_n && out_valid) begin
            got_res_q.push_back(out_result);
            got_err_q.push_back(out_error);
            owed++;
        end
    end

    initial begin
        out_credit = 1'b0;
        forever begin
            @(negedge clk);
            out_credit = credit_next;
        end
    end

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Opcode rules, computed wide and cut to DATA_WIDTH.
    function automatic logic [DATA_WIDTH-1:0] model_result(input alu_op_e op,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        logic [31:0] wide;
        case (op)
            op_add:  wide = 32'(a) + 32'(b);
            op_sub:  wide = 32'(a) + ~32'(b) + 32'd1;
            op_and:  wide = 32'(a & b);
            op_xor:  wide = 32'(a ^ b);
            op_shl:  wide = 32'(a) * (32'd1 << b[3:0]);
            op_max:  wide = (a >= b) ? 32'(a) : 32'(b);
            default: wide = 32'd0;
        endcase
        return wide[DATA_WIDTH-1:0];
    endfunction

    function automatic logic model_error(input alu_op_e op);
        return (op == op_bad6) || (op == op_bad7);
    endfunction

    function automatic int credits_avail();
        return INGRESS_DEPTH + credit_returns - sent;
    endfunction

    task automatic check_result(input string name, input logic [DATA_WIDTH-1:0] got,
            input logic [DATA_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at time %0t: %s got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_error(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error at time %0t: %s got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("Error at time %0t: %s got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_cmd(input alu_op_e op, input logic [DATA_WIDTH-1:0] a,
            input logic [DATA_WIDTH-1:0] b, input logic [DATA_WIDTH-1:0] res, input logic err);
        in_valid     = 1'b1;
        in_opcode    = op;
        in_operand_a = a;
        in_operand_b = b;
        sent++;
        exp_res_q.push_back(res);
        exp_err_q.push_back(err);
    endtask

    // Leaves in_valid high so that sends can follow back to back.
    task automatic send_cmd(input alu_op_e op, input logic [DATA_WIDTH-1:0] a,
            input logic [DATA_WIDTH-1:0] b, input logic [DATA_WIDTH-1:0] res, input logic err);
        int cycles;
        cycles = 0;
        while (credits_avail() <= 0) begin
            in_valid = 1'b0;
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Source received no ingress credit within %0d cycles", TIMEOUT);
                errors++;
                return;
            end
        end
        drive_cmd(op, a, b, res, err);
        @(negedge clk);
    endtask

    task automatic send_row(input int i);
        send_cmd(rows[i].op, rows[i].a, rows[i].b, rows[i].res, rows[i].err);
    endtask

    task automatic wait_for_results(input int n);
        int cycles;
        cycles = 0;
        while (got_res_q.size() - rd_idx < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Sink received %0d of %0d results before the timeout",
                         got_res_q.size() - rd_idx, n);
                errors++;
                return;
            end
        end
    endtask

    // Sink hands back every credit it still owes.
    task automatic drain_sink();
        int cycles;
        cycles = 0;
        while (owed > 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Sink still held %0d results after %0d cycles", owed, TIMEOUT);
                errors++;
                return;
            end
        end
    endtask

    // Compare every queued expectation against the sink's capture, in order.
    task automatic collect();
        wait_for_results(exp_res_q.size());
        while (exp_res_q.size() > 0 && rd_idx < got_res_q.size()) begin
            check_result("out_result", got_res_q[rd_idx], exp_res_q.pop_front());
            check_error("out_error", got_err_q[rd_idx], exp_err_q.pop_front());
            rd_idx++;
        end
        exp_res_q.delete();
        exp_err_q.delete();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err_start) begin
            $display("Test %0d, %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d, %s: %0d errors", tests, name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    task automatic load_table();
        rows[0]  = '{op_add,  16'h1234, 16'h1111, 16'h2345, 1'b0};
        rows[1]  = '{op_add,  16'hffff, 16'h0002, 16'h0001, 1'b0};   // Wraps.
        rows[2]  = '{op_sub,  16'h0005, 16'h0007, 16'hfffe, 1'b0};
        rows[3]  = '{op_and,  16'hf0f0, 16'h3c3c, 16'h3030, 1'b0};
        rows[4]  = '{op_xor,  16'haaaa, 16'h0f0f, 16'ha5a5, 1'b0};
        rows[5]  = '{op_shl,  16'h0003, 16'h0014, 16'h0030, 1'b0};   // Shift by 4.
        rows[6]  = '{op_max,  16'h8000, 16'h7fff, 16'h8000, 1'b0};
        rows[7]  = '{op_max,  16'h0001, 16'hfffe, 16'hfffe, 1'b0};
        rows[8]  = '{op_sub,  16'h1000, 16'h0001, 16'h0fff, 1'b0};
        rows[9]  = '{op_bad6, 16'h1234, 16'h5678, 16'h0000, 1'b1};
        rows[10] = '{op_shl,  16'h8001, 16'h000f, 16'h8000, 1'b0};
        rows[11] = '{op_bad7, 16'hffff, 16'hffff, 16'h0000, 1'b1};
        rows[12] = '{op_xor,  16'h1234, 16'h1234, 16'h0000, 1'b0};
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        int            n;
        int            ret_start;
        int            sent_start;
        alu_op_e       op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;

        reset_n      = 1'b0;
        in_valid     = 1'b0;
        in_opcode    = '0;
        in_operand_a = '0;
        in_operand_b = '0;
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 8; i++) send_row(i);
        in_valid = 1'b0;
        collect();
        end_test("legal opcodes");

        for (int i = 8; i < NUM_ROWS; i++) send_row(i);
        in_valid = 1'b0;
        collect();
        end_test("illegal opcodes");

        drain_sink();
        sink_stall = 1'b1;   // Sink keeps every result it gets.
        for (int i = 0; i < 6; i++) send_row(i);
        in_valid = 1'b0;
        wait_for_results(SINK_CREDITS);
        repeat (20) @(negedge clk);
        check_count("transfers while stalled", got_res_q.size() - rd_idx, SINK_CREDITS);
        sink_stall = 1'b0;
        collect();
        end_test("sink back-pressure");

        // Fill every buffer, then the source must stall.
        drain_sink();
        sink_stall = 1'b1;
        ret_start  = credit_returns;
        sent_start = sent;
        n = 0;
        for (int cyc = 0; cyc < 40; cyc++) begin
            if (credits_avail() > 0) begin
                drive_cmd(rows[n % NUM_ROWS].op, rows[n % NUM_ROWS].a, rows[n % NUM_ROWS].b,
                          rows[n % NUM_ROWS].res, rows[n % NUM_ROWS].err);
                n++;
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        check_count("commands accepted", n, INGRESS_DEPTH + EGRESS_DEPTH + SINK_CREDITS);
        sink_stall = 1'b0;
        for (int i = 0; i < 4; i++) send_row(i);
        in_valid = 1'b0;
        collect();
        check_count("in_credit pulses", credit_returns - ret_start, sent - sent_start);
        end_test("ingress credit flow");

        for (int i = 0; i < 40; i++) begin
            lcg_state = lcg_next(lcg_state);
            op        = alu_op_e'(lcg_state[30:28]);
            lcg_state = lcg_next(lcg_state);
            a         = DATA_WIDTH'(lcg_state >> 16);
            lcg_state = lcg_next(lcg_state);
            b         = DATA_WIDTH'(lcg_state >> 16);
            lcg_state = lcg_next(lcg_state);
            sink_hold = int'(lcg_state[29:28]);
            send_cmd(op, a, b, model_result(op, a, b), model_error(op));
        end
        in_valid = 1'b0;
        collect();
        sink_hold = 0;
        end_test("random burst");

        if (u_dut.u_props.fail_count != 0) begin
            $display("Bound assertions failed %0d times", u_dut.u_props.fail_count);
            errors += u_dut.u_props.fail_count;
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : alu_stream_tb

// ==== src.f ====
logic/stream_pkg.sv
logic/sync_fifo.sv
logic/cmd_ingress.sv
logic/alu_stage.sv
logic/result_egress.sv
logic/alu_stream_top.sv
verification/alu_stream_props.sv
verification/alu_stream_tb.sv

// ==== Makefile ====
TOP       ?= alu_stream_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
